// ==== bench/bch_model.svh ====
`ifndef BCH_MODEL_SVH
`define BCH_MODEL_SVH

// Testbench reference model for BCH(15,7)
// Bit i of a word is the coefficient of x^i

localparam logic [8:0] GEN_POLY = 9'b1_1101_0001; // x^8 + x^7 + x^6 + x^4 + 1
localparam int         PAR_W    = CODE_N - CODE_K; // Parity bits

// Fibonacci LFSR step with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// Remainder of w(x) mod g(x) is zero for a codeword
function automatic logic [PAR_W-1:0] poly_rem(input logic [CODE_N-1:0] w);
	logic [CODE_N-1:0] r;
	int k;
	r = w;
	for (k = CODE_N - 1; k >= PAR_W; k--) begin
		if (r[k])
			r = r ^ (CODE_N'(GEN_POLY) << (k - PAR_W)); // Cancel the top term
	end
	return r[PAR_W-1:0];
endfunction

// Systematic encode with the message in the top seven bits
function automatic logic [CODE_N-1:0] encode_msg(input logic [CODE_K-1:0] msg);
	logic [CODE_N-1:0] shifted;
	shifted = {msg, {PAR_W{1'b0}}};
	return shifted | CODE_N'(poly_rem(shifted));
endfunction

function automatic logic is_codeword(input logic [CODE_N-1:0] w);
	return poly_rem(w) == '0;
endfunction

// Number of ones in a word
function automatic int bit_weight(input logic [CODE_N-1:0] w);
	int n;
	int i;
	n = 0;
	for (i = 0; i < CODE_N; i++) begin
		if (w[i])
			n++;
	end
	return n;
endfunction

// Error pattern of two bits or less that makes w a codeword
// All ones when no such pattern exists
function automatic logic [CODE_N-1:0] small_error(input logic [CODE_N-1:0] w);
	logic [CODE_N-1:0] e;
	logic [CODE_N-1:0] best;
	int i;
	int j;
	best = is_codeword(w) ? '0 : '1;
	for (i = 0; i < CODE_N; i++) begin
		for (j = i; j < CODE_N; j++) begin
			e = (CODE_N'(1) << i) | (CODE_N'(1) << j); // j == i gives one bit
			if (best == '1 && is_codeword(w ^ e))
				best = e;
		end
	end
	return best;
endfunction

`endif

// ==== bench/bch_tb.sv ====
`timescale 1ns/1ns

// Directed tests for the BCH(15,7) decoder
module bch_tb
	import bch_pkg::*;
();

	localparam int WORD_CYCLES    = 40;  // Upper bound on cycles per word
	localparam int MAX_WORDS      = 60;  // 48 words in the tests plus stall room
	localparam int TIMEOUT_CYCLES = 2 * MAX_WORDS * WORD_CYCLES + 200;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	logic [CODE_N-1:0] in_word;
	logic              out_valid;
	logic              out_ready;
	logic [CODE_N-1:0] out_word;
	logic              out_fail;
	logic [1:0]        out_nerr;

	logic [31:0]       lfsr;
	logic [CODE_N-1:0] res_word;      // Captured when out_valid rises
	logic              res_fail;
	logic [1:0]        res_nerr;
	int                cycles = 0;
	int                errs;          // Errors in the running test
	int                tests_ok = 0;
	int                tests_bad = 0;
	string             cur_test;

	`include "bch_model.svh"

	bch_decoder dut0 (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
		.in_word(in_word), .out_valid(out_valid), .out_ready(out_ready),
		.out_word(out_word), .out_fail(out_fail), .out_nerr(out_nerr));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: no progress after %0d cycles in test %s", cycles, cur_test);
			$display("sim failed");
			$finish;
		end
	end

	// n fresh bits with one LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Position 0..14 with draws of 15 redrawn
	function automatic int rand_pos();
		int p;
		p = CODE_N;
		while (p >= CODE_N)
			p = int'(rand_bits(CNT_W));
		return p;
	endfunction

	// Error pattern with nflip distinct positions
	function automatic logic [CODE_N-1:0] rand_flips(input int nflip);
		logic [CODE_N-1:0] f;
		f = '0;
		while (bit_weight(f) < nflip)
			f = f | (CODE_N'(1) << rand_pos()); // Repeats leave f unchanged
		return f;
	endfunction

	task automatic value_error(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("** Error %s: %s expected %h actual %h", cur_test, what, exp, act);
		errs++;
	endtask

	task automatic note_error(input string what);
		$display("Error in %s: %s", cur_test, what);
		errs++;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errs     = 0;
	endtask

	task automatic end_test();
		if (errs == 0) begin
			$display("test %s done, no errors", cur_test);
			tests_ok++;
		end else begin
			$display("test %s done, %0d errors", cur_test, errs);
			tests_bad++;
		end
	endtask

	// One clock and then 1 ns past the edge
	task automatic step_clk();
		@(posedge clk);
		#1;
	endtask

	// Send a word and hold out_ready low for hold cycles before taking the result
	task automatic run_word(input logic [CODE_N-1:0] w, input int hold);
		out_ready = (hold == 0);
		in_valid  = 1'b1;
		in_word   = w;
		while (!in_ready)
			step_clk();
		step_clk();                 // Word taken on this edge
		in_valid = 1'b0;
		while (!out_valid)
			step_clk();
		res_word = out_word;
		res_fail = out_fail;
		res_nerr = out_nerr;
		repeat (hold) begin
			step_clk();
			if (!out_valid)
				note_error("out_valid dropped while out_ready was low");
			if (out_word !== res_word)
				value_error("held out_word", 32'(res_word), 32'(out_word));
			if (out_fail !== res_fail || out_nerr !== res_nerr)
				note_error("out_fail or out_nerr changed while out_ready was low");
			if (in_ready)
				note_error("in_ready rose before the result was taken");
		end
		out_ready = 1'b1;
		step_clk();
		if (out_valid || !in_ready)
			note_error("decoder did not return to idle after the result was taken");
	endtask

	task automatic expect_decoded(input logic [CODE_N-1:0] cw, input logic [1:0] nerr);
		if (res_word !== cw)
			value_error("out_word", 32'(cw), 32'(res_word));
		if (res_nerr !== nerr)
			value_error("out_nerr", 32'(nerr), 32'(res_nerr));
		if (res_fail !== 1'b0)
			value_error("out_fail", 32'(0), 32'(res_fail));
	endtask

	task automatic test_reset_clean();
		logic [CODE_N-1:0] cw;
		start_test("reset_clean");
		if (in_ready !== 1'b1)
			value_error("in_ready after reset", 32'(1), 32'(in_ready));
		if (out_valid !== 1'b0)
			value_error("out_valid after reset", 32'(0), 32'(out_valid));
		cw = encode_msg(CODE_K'(rand_bits(CODE_K)));
		run_word(cw, 0);
		expect_decoded(cw, 2'd0);   // Clean word passes through
		end_test();
	endtask

	// One error swept over every position
	task automatic test_single_sweep();
		logic [CODE_N-1:0] cw;
		int p;
		start_test("single_sweep");
		for (p = 0; p < CODE_N; p++) begin
			cw = encode_msg(CODE_K'(rand_bits(CODE_K)));
			run_word(cw ^ (CODE_N'(1) << p), 0);
			expect_decoded(cw, 2'd1);
		end
		end_test();
	endtask

	// Random codewords with nflip distinct errors each
	task automatic test_random_flips(input string name, input int words, input int nflip);
		logic [CODE_N-1:0] cw;
		logic [CODE_N-1:0] rx;
		logic [CODE_N-1:0] fix;     // Nearest correction found by the model
		start_test(name);
		repeat (words) begin
			cw = encode_msg(CODE_K'(rand_bits(CODE_K)));
			rx = cw ^ rand_flips(nflip);
			run_word(rx, 0);
			if (nflip <= CODE_T) begin
				expect_decoded(cw, 2'(nflip));
			end else begin
				fix = small_error(rx);
				if (bit_weight(fix) <= CODE_T)
					expect_decoded(rx ^ fix, 2'(bit_weight(fix))); // Neighbouring codeword
				else begin
					// No codeword within two bits
					if (res_fail !== 1'b1)
						value_error("out_fail", 32'(1), 32'(res_fail));
					if (res_word !== rx)
						value_error("out_word on failure", 32'(rx), 32'(res_word));
				end
			end
		end
		end_test();
	endtask

	// Result held under back-pressure before a follow-up word
	task automatic test_backpressure();
		logic [CODE_N-1:0] cw;
		int hold;
		start_test("backpressure");
		hold = 1 + int'(rand_bits(5));   // 1..32 cycles
		cw   = encode_msg(CODE_K'(rand_bits(CODE_K)));
		run_word(cw ^ rand_flips(2), hold);
		expect_decoded(cw, 2'd2);
		cw = encode_msg(CODE_K'(rand_bits(CODE_K)));
		run_word(cw ^ rand_flips(1), 0);
		expect_decoded(cw, 2'd1);
		end_test();
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_word   = '0;
		out_ready = 1'b1;
		lfsr      = 32'hd83521af;
		cur_test  = "reset";
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_clean();
		test_single_sweep();
		test_random_flips("double_random", 20, 2);
		test_random_flips("triple_random", 10, 3);
		test_backpressure();
		$display("tests passed %0d, tests failed %0d", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== logic/bch_decoder.sv ====
`timescale 1ns/1ns

// BCH(15,7) two error decoder, one word in flight
module bch_decoder
	import bch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [CODE_N-1:0] in_word,
	output logic              out_valid,
	input  logic              out_ready,
	output logic [CODE_N-1:0] out_word,
	output logic              out_fail,
	output logic [1:0]        out_nerr
);

	dec_state_t        state;
	logic [CODE_N-1:0] word_q;      // Received word
	logic [CODE_N-1:0] mask;        // Error positions found so far
	logic [CODE_N-1:0] mask_nxt;
	logic [1:0]        roots;       // Chien roots found so far
	logic [1:0]        roots_nxt;
	logic              syn_start;
	logic              syn_done;
	logic [GF_M-1:0]   s1;
	logic [GF_M-1:0]   s3;
	logic [GF_M-1:0]   sigma1;
	logic [GF_M-1:0]   sigma2;
	logic [1:0]        loc_nerr;
	logic              loc_fail;
	logic              chs_start;
	logic              pos_valid;
	logic              err_bit;
	logic [CNT_W-1:0]  pos;
	logic              chs_done;
	logic              hit;
	logic              bad;         // Uncorrectable

	syndrome_calc synd0 (.clk(clk), .rst_n(rst_n), .start(syn_start), .word(word_q),
		.done(syn_done), .s1(s1), .s3(s3));

	error_locator loc0 (.clk(clk), .rst_n(rst_n), .load(syn_done), .s1(s1), .s3(s3),
		.sigma1(sigma1), .sigma2(sigma2), .nerr(loc_nerr), .fail(loc_fail));

	chien_search chs0 (.clk(clk), .rst_n(rst_n), .start(chs_start), .sigma1(sigma1),
		.sigma2(sigma2), .pos_valid(pos_valid), .err_bit(err_bit), .pos(pos),
		.done(chs_done));

	assign in_ready  = (state == ST_IDLE);
	assign out_valid = (state == ST_OUTPUT);
	assign chs_start = (state == ST_LOCATE); // Locator result is ready here

	// Fold in this cycle's report so the last position counts at done
	assign hit       = pos_valid && err_bit;
	assign mask_nxt  = mask | (hit ? (CODE_N'(1) << pos) : '0);
	assign roots_nxt = roots + {1'b0, hit};
	assign bad       = loc_fail || (roots_nxt != loc_nerr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			syn_start <= 1'b0;
			roots     <= '0;
			out_fail  <= 1'b0;
			out_nerr  <= '0;
		end else begin
			syn_start <= 1'b0;
			case (state)
				ST_IDLE: if (in_valid) begin
					state     <= ST_SYND;
					syn_start <= 1'b1;
				end
				ST_SYND:   if (syn_done) state <= ST_LOCATE;
				ST_LOCATE: begin
					state <= ST_SEARCH;
					roots <= '0;
				end
				ST_SEARCH: begin
					roots <= roots_nxt;
					if (chs_done) begin
						state    <= ST_OUTPUT;
						out_fail <= bad;
						out_nerr <= bad ? 2'(CODE_T + 1) : loc_nerr;
					end
				end
				ST_OUTPUT: if (out_ready) state <= ST_IDLE; // Result taken
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Word buffer, mask and corrected result
	always_ff @(posedge clk) begin
		if (in_ready && in_valid)
			word_q <= in_word;
		if (chs_start)
			mask <= '0;
		else if (state == ST_SEARCH)
			mask <= mask_nxt;
		if (state == ST_SEARCH && chs_done)
			out_word <= bad ? word_q : (word_q ^ mask_nxt); // Raw word on failure
	end

endmodule

// ==== logic/bch_pkg.sv ====
package bch_pkg;

	// BCH(15,7) over GF(2^4), corrects two bit errors
	localparam int GF_M   = 4;    // Field degree and element width
	localparam int CODE_N = 15;   // Codeword length
	localparam int CODE_K = 7;    // Message length
	localparam int CODE_T = 2;    // Correctable errors
	localparam int CNT_W  = 4;    // Wide enough for positions 0..14

	// x^4 + x + 1
	localparam logic [GF_M:0] FIELD_POLY = 5'b10011;

	// Decoder sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SYND,
		ST_LOCATE,
		ST_SEARCH,
		ST_OUTPUT
	} dec_state_t;

	// alpha^e by repeated multiplication by x
	function automatic logic [GF_M-1:0] gf_pow(input int e);
		logic [GF_M:0] v;
		int k;
		v = 1;
		for (k = 0; k < e; k++) begin
			v = v << 1;
			if (v[GF_M])
				v = v ^ FIELD_POLY; // Reduce back into the field
		end
		return v[GF_M-1:0];
	endfunction

	// Inverse lookup, zero maps to zero
	function automatic logic [GF_M-1:0] gf_inv(input logic [GF_M-1:0] a);
		case (a)
			4'd1:    return 4'd1;
			4'd2:    return 4'd9;   // alpha^1 -> alpha^14
			4'd3:    return 4'd14;
			4'd4:    return 4'd13;
			4'd5:    return 4'd11;
			4'd6:    return 4'd7;
			4'd7:    return 4'd6;
			4'd8:    return 4'd15;
			4'd9:    return 4'd2;
			4'd10:   return 4'd12;
			4'd11:   return 4'd5;
			4'd12:   return 4'd10;
			4'd13:   return 4'd4;
			4'd14:   return 4'd3;
			4'd15:   return 4'd8;
			default: return 4'd0;
		endcase
	endfunction

endpackage

// ==== logic/chien_reg.sv ====
`timescale 1ns/1ns

// Chien term register, sigma_i times alpha^(STEP_POW*n) after n steps
module chien_reg
	import bch_pkg::*;
#(
	parameter int STEP_POW = 1
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,
	input  logic            step,
	input  logic [GF_M-1:0] coef_in,
	output logic [GF_M-1:0] coef_out
);

	localparam logic [GF_M-1:0] STEP_C = gf_pow(STEP_POW);

	logic [GF_M-1:0] coef_mul;

	gf_mul mul0 (
		.a (coef_out),
		.b (STEP_C),
		.p (coef_mul)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			coef_out <= '0;
		else if (load)
			coef_out <= coef_in;   // Load wins over step
		else if (step)
			coef_out <= coef_mul;
	end

endmodule

// ==== logic/chien_search.sv ====
`timescale 1ns/1ns

// Chien search over all 15 positions
// One load cycle, then search cycle c tests position 14 - c
// Registers have been stepped c + 1 times by then
// so they hold sigma_i * alpha^(i*(c+1)), and alpha^(c+1) = alpha^-(14-c)
module chien_search
	import bch_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,      // Latch sigma
	input  logic [GF_M-1:0]  sigma1,
	input  logic [GF_M-1:0]  sigma2,
	output logic             pos_valid,  // High for 15 cycles
	output logic             err_bit,    // Position pos is in error
	output logic [CNT_W-1:0] pos,
	output logic             done        // Last position this cycle
);

	logic                  first;        // Step from load into search
	logic                  step;
	logic [GF_M-1:0]       z0;
	logic [GF_M-1:0]       z1;
	logic [GF_M-1:0]       z2;
	logic [GF_M-1:0]       sum;

	assign step = first || pos_valid;

	// Constant term of the locator
	chien_reg #(.STEP_POW(0)) reg0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (start),
		.step     (step),
		.coef_in  ({{(GF_M-1){1'b0}}, 1'b1}),
		.coef_out (z0)
	);

	chien_reg #(.STEP_POW(1)) reg1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (start),
		.step     (step),
		.coef_in  (sigma1),
		.coef_out (z1)
	);

	chien_reg #(.STEP_POW(2)) reg2 (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (start),
		.step     (step),
		.coef_in  (sigma2),
		.coef_out (z2)
	);

	// sigma evaluated at the current point
	assign sum     = z0 ^ z1 ^ z2;
	assign err_bit = pos_valid && (sum == '0);
	assign done    = pos_valid && (pos == '0);

	// Position counter, counts down from the top
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first     <= 1'b0;
			pos_valid <= 1'b0;
			pos       <= '0;
		end else begin
			first <= start;
			if (first) begin
				pos_valid <= 1'b1;
				pos       <= CNT_W'(CODE_N - 1);
			end else if (pos_valid) begin
				if (pos == '0)
					pos_valid <= 1'b0;     // All positions tested
				else
					pos <= pos - 1'b1;
			end
		end
	end

endmodule

// ==== logic/error_locator.sv ====
`timescale 1ns/1ns

// Direct double error solution
// sigma(x) = 1 + S1*x + (S1^2 + S3/S1)*x^2
// S1 = 0 and S3 = 0 gives no errors
// S1 != 0 and S3 = S1^3 gives one error
// S1 != 0 otherwise gives two errors
// S1 = 0 with S3 != 0 cannot be corrected
module error_locator
	import bch_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,
	input  logic [GF_M-1:0] s1,
	input  logic [GF_M-1:0] s3,
	output logic [GF_M-1:0] sigma1,
	output logic [GF_M-1:0] sigma2,
	output logic [1:0]      nerr,   // Expected root count
	output logic            fail
);

	logic [GF_M-1:0] s1_sq;
	logic [GF_M-1:0] s1_cu;
	logic [GF_M-1:0] s3_div;   // S3 * S1^-1
	logic            s1_zero;
	logic            s3_zero;
	logic            one_err;

	gf_mul mul_sq (
		.a (s1),
		.b (s1),
		.p (s1_sq)
	);

	gf_mul mul_cu (
		.a (s1_sq),
		.b (s1),
		.p (s1_cu)
	);

	gf_mul mul_div (
		.a (s3),
		.b (gf_inv(s1)),
		.p (s3_div)
	);

	assign s1_zero = (s1 == '0);
	assign s3_zero = (s3 == '0);
	assign one_err = !s1_zero && (s3 == s1_cu);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nerr <= '0;
			fail <= 1'b0;
		end else if (load) begin
			fail <= s1_zero && !s3_zero;
			if (s1_zero)
				nerr <= s3_zero ? 2'd0 : 2'(CODE_T + 1); // More than T
			else
				nerr <= one_err ? 2'd1 : 2'(CODE_T);
		end
	end

	// Coefficients
	always_ff @(posedge clk) begin
		if (load) begin
			sigma1 <= s1;
			sigma2 <= one_err ? '0 : (s1_sq ^ s3_div); // Degree one locator
		end
	end

endmodule

// ==== logic/gf_mul.sv ====
`timescale 1ns/1ns

// GF(2^4) multiply in polynomial basis
module gf_mul
	import bch_pkg::*;
(
	input  logic [GF_M-1:0] a,
	input  logic [GF_M-1:0] b,
	output logic [GF_M-1:0] p
);

	logic [2*GF_M-2:0] prod; // Up to degree 6 before reduction

	always_comb begin
		prod = '0;
		// Carry-less product
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				prod = prod ^ ({{(GF_M-1){1'b0}}, a} << i);
		end
		// Fold high terms down, top bit first
		for (int k = 2*GF_M-2; k >= GF_M; k--) begin
			if (prod[k])
				prod = prod ^ ({{(GF_M-2){1'b0}}, FIELD_POLY} << (k - GF_M));
		end
		p = prod[GF_M-1:0];
	end

endmodule

// ==== logic/syndrome_calc.sv ====
`timescale 1ns/1ns

// Odd syndromes S1 = r(alpha) and S3 = r(alpha^3)
// Horner form, one received bit per cycle, top position first
module syndrome_calc
	import bch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,  // Word is stable from here to done
	input  logic [CODE_N-1:0] word,
	output logic              done,
	output logic [GF_M-1:0]   s1,
	output logic [GF_M-1:0]   s3
);

	localparam logic [GF_M-1:0] ALPHA1 = gf_pow(1);
	localparam logic [GF_M-1:0] ALPHA3 = gf_pow(3);

	logic             busy;
	logic [CNT_W-1:0] cnt;      // Position of the next bit to add
	logic [GF_M-1:0]  s1_mul;
	logic [GF_M-1:0]  s3_mul;
	logic [GF_M-1:0]  cur_bit;  // Received bit as a field element

	gf_mul mul_s1 (
		.a (s1),
		.b (ALPHA1),
		.p (s1_mul)
	);

	gf_mul mul_s3 (
		.a (s3),
		.b (ALPHA3),
		.p (s3_mul)
	);

	assign cur_bit = {{(GF_M-1){1'b0}}, word[cnt]};

	// Bit counter and done pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(CODE_N - 2); // Top bit goes in on the start edge
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					done <= 1'b1;           // Bit 0 just added
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	// Accumulators
	always_ff @(posedge clk) begin
		if (start) begin
			// Zero accumulator times alpha is zero, so just the top bit
			s1 <= {{(GF_M-1){1'b0}}, word[CODE_N-1]};
			s3 <= {{(GF_M-1){1'b0}}, word[CODE_N-1]};
		end else if (busy) begin
			s1 <= s1_mul ^ cur_bit;
			s3 <= s3_mul ^ cur_bit;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the BCH(15,7) decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module bch_tb \
	-f verilog.f -o bch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/bch_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== verilog.f ====
+incdir+bench
logic/bch_pkg.sv
logic/gf_mul.sv
logic/syndrome_calc.sv
logic/error_locator.sv
logic/chien_reg.sv
logic/chien_search.sv
logic/bch_decoder.sv
bench/bch_tb.sv
